// ==== Bender.yml ====
package:
  name: gfx_fade_display

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fade_fb_pkg.sv
      - hdl/gfx_credit_intake.sv
      - hdl/fade_fb_store.sv
      - hdl/pixel_fade_unit.sv
      - hdl/raster_scan.sv
      - hdl/gfx_fade_display.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clock_gen.sv
      - tests/gfx_fade_display_tb.sv

// ==== flist.f ====
+incdir+hdl
hdl/fade_fb_pkg.sv
hdl/gfx_credit_intake.sv
hdl/fade_fb_store.sv
hdl/pixel_fade_unit.sv
hdl/raster_scan.sv
hdl/gfx_fade_display.sv
tests/tb_clock_gen.sv
tests/gfx_fade_display_tb.sv

// ==== hdl/fade_fb_cfg.svh ====
`ifndef FADE_FB_CFG_SVH
`define FADE_FB_CFG_SVH

// horizontal timing in clk cycles
`define FB_H_VISIBLE 16
`define FB_H_FRONT   2
`define FB_H_SYNC    3
`define FB_H_BACK    3
`define FB_H_WHOLE   24

// vertical timing in lines
`define FB_V_VISIBLE 8
`define FB_V_FRONT   1
`define FB_V_SYNC    1
`define FB_V_BACK    2
`define FB_V_WHOLE   12

// stored pixel is age next to color
`define FB_COLOR_BITS 12
`define FB_AGE_BITS   4

// one entry per visible pixel
`define FB_DEPTH     128
`define FB_ADDR_BITS 7

// intake queue depth, also the credits a client starts with
`define GFX_CREDITS 4

// fresh pixels get START, color halves when the new age reaches DIM
`define FADE_START_AGE 4
`define FADE_DIM_AGE   2

`endif

// ==== hdl/fade_fb_pkg.sv ====
`include "fade_fb_cfg.svh"

package fade_fb_pkg;

  // raster coordinates within the visible area
  typedef logic [$clog2(`FB_H_VISIBLE)-1:0] fb_x_t;
  typedef logic [$clog2(`FB_V_VISIBLE)-1:0] fb_y_t;

  // linear address, row * FB_H_VISIBLE + column
  typedef logic [`FB_ADDR_BITS-1:0] fb_addr_t;

  // color is red, green, blue with red in the top bits
  typedef logic [`FB_COLOR_BITS-1:0]   color_t;
  typedef logic [`FB_COLOR_BITS/3-1:0] channel_t;
  typedef logic [`FB_AGE_BITS-1:0]     age_t;

  typedef struct packed {
    age_t   age;
    color_t color;
  } fb_pixel_t;

  // draw command from the client
  typedef struct packed {
    fb_x_t  x;
    fb_y_t  y;
    color_t color;
  } gfx_cmd_t;

  // one request on the memory write port
  typedef struct packed {
    logic      valid;
    fb_addr_t  addr;
    fb_pixel_t pixel;
  } fb_write_t;

  typedef struct packed {
    channel_t red;
    channel_t grn;
    channel_t blu;
    logic     hsync;
    logic     vsync;
    logic     visible;
  } vga_out_t;

  // vertical phase of the raster
  typedef enum logic [1:0] {VISIBLE, FRONT, SYNC, BACK} scan_phase_e;

endpackage

// ==== hdl/fade_fb_store.sv ====
`timescale 1ns/1ps
`include "fade_fb_cfg.svh"

module fade_fb_store (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   rd_en,
  input  fade_fb_pkg::fb_addr_t  rd_addr,
  output fade_fb_pkg::fb_pixel_t rd_pixel,
  output fade_fb_pkg::fb_addr_t  rd_addr_q,
  input  fade_fb_pkg::fb_write_t fade_wr,
  input  fade_fb_pkg::fb_write_t draw_wr,
  output logic                   draw_taken
);
  import fade_fb_pkg::*;

  fb_pixel_t            mem [`FB_DEPTH];
  logic [`FB_DEPTH-1:0] pix_valid;
  fb_write_t            wr;

  // writeback wins the single write port, draws wait for a free cycle
  always_comb begin
    if (fade_wr.valid) begin
      wr = fade_wr;
    end else begin
      wr = draw_wr;
    end
  end

  assign draw_taken = draw_wr.valid && !fade_wr.valid;

  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.pixel;
    end
  end

  // entries never written since reset read as black with age 0
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pix_valid <= '0;
    end else if (wr.valid) begin
      pix_valid[wr.addr] <= 1'b1;
    end
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (pix_valid[rd_addr]) begin
        rd_pixel <= mem[rd_addr];
      end else begin
        rd_pixel <= '0;
      end
      rd_addr_q <= rd_addr;
    end
  end

  // an expired pixel must be stored black
  a_dead_is_black: assert property (
    @(posedge clk) disable iff (!arst_n)
    fade_wr.valid && (fade_wr.pixel.age == '0) |-> (fade_wr.pixel.color == '0)
  ) else $error("fade writeback with age 0 keeps a color");

endmodule

// ==== hdl/gfx_credit_intake.sv ====
`timescale 1ns/1ps
`include "fade_fb_cfg.svh"

module gfx_credit_intake (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   gfx_push,
  input  fade_fb_pkg::gfx_cmd_t  gfx_cmd,
  output fade_fb_pkg::fb_write_t draw_wr,
  input  logic                   draw_taken,
  output logic                   gfx_credit
);
  import fade_fb_pkg::*;

  localparam int DEPTH    = `GFX_CREDITS;
  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  gfx_cmd_t            queue [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                empty;
  logic                full;
  logic                do_push;
  logic                do_pop;
  gfx_cmd_t            head;

  function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == CNT_BITS'(DEPTH));
  assign do_push = gfx_push && !full;
  assign do_pop  = draw_taken && !empty;

  // a credit goes back the same cycle the store takes the head
  assign gfx_credit = do_pop;

  assign head = queue[rd_ptr];

  always_comb begin
    draw_wr.valid       = !empty;
    draw_wr.addr        = fb_addr_t'(head.y) * fb_addr_t'(`FB_H_VISIBLE) + fb_addr_t'(head.x);
    // new pixels start fully lit
    draw_wr.pixel.age   = age_t'(`FADE_START_AGE);
    draw_wr.pixel.color = head.color;
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      queue[wr_ptr] <= gfx_cmd;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // client holds no credit while all slots are in use
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!arst_n) gfx_push |-> !full
  ) else $error("draw pushed into a full intake queue");

  // the store only claims a draw when the queue offers one
  a_no_take_empty: assert property (
    @(posedge clk) disable iff (!arst_n) draw_taken |-> !empty
  ) else $error("draw taken from an empty intake queue");

endmodule

// ==== hdl/gfx_fade_display.sv ====
`timescale 1ns/1ps

module gfx_fade_display (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  vga_enable,
  input  logic                  gfx_push,
  input  fade_fb_pkg::gfx_cmd_t gfx_cmd,
  output logic                  gfx_credit,
  output fade_fb_pkg::vga_out_t vga_out
);
  import fade_fb_pkg::*;

  fb_write_t draw_wr;
  logic      draw_taken;
  logic      rd_en;
  fb_addr_t  rd_addr;
  fb_pixel_t rd_pixel;
  fb_addr_t  rd_addr_q;
  fb_write_t fade_wr;

  gfx_credit_intake u_gfx_credit_intake (
    .clk        (clk),
    .arst_n     (arst_n),
    .gfx_push   (gfx_push),
    .gfx_cmd    (gfx_cmd),
    .draw_wr    (draw_wr),
    .draw_taken (draw_taken),
    .gfx_credit (gfx_credit)
  );

  fade_fb_store u_fade_fb_store (
    .clk        (clk),
    .arst_n     (arst_n),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_pixel   (rd_pixel),
    .rd_addr_q  (rd_addr_q),
    .fade_wr    (fade_wr),
    .draw_wr    (draw_wr),
    .draw_taken (draw_taken)
  );

  // the fade unit lines the read enable up with the returned data itself
  pixel_fade_unit u_pixel_fade_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_valid  (rd_en),
    .rd_pixel  (rd_pixel),
    .rd_addr_q (rd_addr_q),
    .fade_wr   (fade_wr)
  );

  raster_scan u_raster_scan (
    .clk        (clk),
    .arst_n     (arst_n),
    .vga_enable (vga_enable),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_pixel   (rd_pixel),
    .vga_out    (vga_out)
  );

endmodule

// ==== hdl/pixel_fade_unit.sv ====
`timescale 1ns/1ps
`include "fade_fb_cfg.svh"

module pixel_fade_unit (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   rd_valid,
  input  fade_fb_pkg::fb_pixel_t rd_pixel,
  input  fade_fb_pkg::fb_addr_t  rd_addr_q,
  output fade_fb_pkg::fb_write_t fade_wr
);
  import fade_fb_pkg::*;

  logic      rd_valid_q;
  age_t      new_age;
  channel_t  red;
  channel_t  grn;
  channel_t  blu;
  fb_pixel_t aged;
  logic      wr_valid_q;
  fb_addr_t  wr_addr_q;
  fb_pixel_t wr_pixel_q;

  assign {red, grn, blu} = rd_pixel.color;

  always_comb begin
    new_age  = rd_pixel.age - 1'b1;
    aged.age = new_age;
    if (new_age == age_t'(`FADE_DIM_AGE)) begin
      // half brightness on each channel
      aged.color = {red >> 1, grn >> 1, blu >> 1};
    end else if (new_age == '0) begin
      aged.color = '0;
    end else begin
      aged.color = rd_pixel.color;
    end
  end

  // read data arrives one cycle after the scanner's enable
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid_q <= 1'b0;
      wr_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_valid;
      // pixels already at age 0 stay as they are
      wr_valid_q <= rd_valid_q && (rd_pixel.age != '0);
    end
  end

  always_ff @(posedge clk) begin
    wr_addr_q  <= rd_addr_q;
    wr_pixel_q <= aged;
  end

  always_comb begin
    fade_wr.valid = wr_valid_q;
    fade_wr.addr  = wr_addr_q;
    fade_wr.pixel = wr_pixel_q;
  end

endmodule

// ==== hdl/raster_scan.sv ====
`timescale 1ns/1ps
`include "fade_fb_cfg.svh"

module raster_scan (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   vga_enable,
  output logic                   rd_en,
  output fade_fb_pkg::fb_addr_t  rd_addr,
  input  fade_fb_pkg::fb_pixel_t rd_pixel,
  output fade_fb_pkg::vga_out_t  vga_out
);
  import fade_fb_pkg::*;

  localparam int H_BITS   = $clog2(`FB_H_WHOLE);
  localparam int HS_START = `FB_H_VISIBLE + `FB_H_FRONT;
  localparam int HS_END   = HS_START + `FB_H_SYNC;

  logic [H_BITS-1:0] h_cnt;
  scan_phase_e       phase;
  scan_phase_e       phase_next;
  fb_y_t             row;
  fb_y_t             phase_last;
  logic              line_end;
  logic              phase_end;
  logic              h_visible;
  logic              hsync_now;
  logic              vsync_now;
  logic              vis_d1;
  logic              hsync_d1;
  logic              vsync_d1;
  channel_t          red;
  channel_t          grn;
  channel_t          blu;

  if (`FB_H_VISIBLE + `FB_H_FRONT + `FB_H_SYNC + `FB_H_BACK != `FB_H_WHOLE) begin : g_h_check
    $error("horizontal timing does not add up to a whole line");
  end
  if (`FB_V_VISIBLE + `FB_V_FRONT + `FB_V_SYNC + `FB_V_BACK != `FB_V_WHOLE) begin : g_v_check
    $error("vertical timing does not add up to a whole frame");
  end

  // last row of each phase and the phase that follows it
  always_comb begin
    case (phase)
      VISIBLE: begin
        phase_last = fb_y_t'(`FB_V_VISIBLE - 1);
        phase_next = FRONT;
      end
      FRONT: begin
        phase_last = fb_y_t'(`FB_V_FRONT - 1);
        phase_next = SYNC;
      end
      SYNC: begin
        phase_last = fb_y_t'(`FB_V_SYNC - 1);
        phase_next = BACK;
      end
      default: begin
        phase_last = fb_y_t'(`FB_V_BACK - 1);
        phase_next = VISIBLE;
      end
    endcase
  end

  assign line_end  = (h_cnt == H_BITS'(`FB_H_WHOLE - 1));
  assign phase_end = (row == phase_last);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_cnt <= '0;
      row   <= '0;
      phase <= VISIBLE;
    end else if (vga_enable) begin
      if (line_end) begin
        h_cnt <= '0;
        if (phase_end) begin
          row   <= '0;
          phase <= phase_next;
        end else begin
          row <= row + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  assign h_visible = (h_cnt < H_BITS'(`FB_H_VISIBLE));
  assign hsync_now = (h_cnt >= H_BITS'(HS_START)) && (h_cnt < H_BITS'(HS_END));
  assign vsync_now = (phase == SYNC);

  // row counts visible lines while in the VISIBLE phase
  assign rd_en   = vga_enable && h_visible && (phase == VISIBLE);
  assign rd_addr = fb_addr_t'(row) * fb_addr_t'(`FB_H_VISIBLE) + fb_addr_t'(h_cnt);

  assign {red, grn, blu} = rd_pixel.color;

  // flags wait one cycle for the memory read and then share the output register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vis_d1   <= 1'b0;
      hsync_d1 <= 1'b0;
      vsync_d1 <= 1'b0;
      vga_out  <= '0;
    end else begin
      vis_d1          <= rd_en;
      hsync_d1        <= hsync_now;
      vsync_d1        <= vsync_now;
      vga_out.red     <= vis_d1 ? red : '0;
      vga_out.grn     <= vis_d1 ? grn : '0;
      vga_out.blu     <= vis_d1 ? blu : '0;
      vga_out.hsync   <= hsync_d1;
      vga_out.vsync   <= vsync_d1;
      vga_out.visible <= vis_d1;
    end
  end

endmodule

// ==== tests/gfx_fade_display_tb.sv ====
`timescale 1ns/1ps
`include "fade_fb_cfg.svh"

module gfx_fade_display_tb;
  import fade_fb_pkg::*;

  localparam int     CLK_PERIOD   = 4;
  localparam int     NPIX         = `FB_H_VISIBLE * `FB_V_VISIBLE;
  localparam int     FRAME_CYCLES = `FB_H_WHOLE * `FB_V_WHOLE;
  localparam int     RUN_FRAMES   = 40;
  localparam longint WATCHDOG_NS  = longint'(RUN_FRAMES + 4) * FRAME_CYCLES * CLK_PERIOD;

  logic     clk;
  logic     arst_n;
  logic     vga_enable;
  logic     gfx_push;
  gfx_cmd_t gfx_cmd;
  logic     gfx_credit;
  vga_out_t vga_out;

  // reference framebuffer and the last color seen at each position
  age_t   model_age   [NPIX];
  color_t model_color [NPIX];
  color_t shown       [NPIX];

  int   errors;
  int   test_err0;
  int   tests_run;
  int   tests_failed;
  int   pix_idx;
  int   frames_shown;
  int   outstanding;
  int   credits_seen;
  logic credit_armed;
  time  first_credit_t;
  logic timing_on;
  int   timing_checks;
  int   vis_run;
  int   hs_run;
  int   vs_run;
  int   vis_lines;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_tb_clock_gen (.clk(clk));

  gfx_fade_display u_gfx_fade_display (
    .clk        (clk),
    .arst_n     (arst_n),
    .vga_enable (vga_enable),
    .gfx_push   (gfx_push),
    .gfx_cmd    (gfx_cmd),
    .gfx_credit (gfx_credit),
    .vga_out    (vga_out)
  );

  function automatic color_t halve_color(input color_t c);
    return {c[11:8] >> 1, c[7:4] >> 1, c[3:0] >> 1};
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("FAIL at %0t: %s", $time, msg);
  endtask

  // checks pixels, credits and raster timing on each rising edge
  always @(posedge clk) begin
    if (!arst_n) begin
      pix_idx     = 0;
      outstanding = 0;
      vis_run     = 0;
      hs_run      = 0;
      vs_run      = 0;
      vis_lines   = 0;
    end else begin
      if (vga_out.vsync) begin
        pix_idx = 0;
      end else if (vga_out.visible) begin
        shown[pix_idx] = {vga_out.red, vga_out.grn, vga_out.blu};
        if (shown[pix_idx] !== model_color[pix_idx]) begin
          report_error($sformatf("pixel %0d shows %h, expected %h",
                                 pix_idx, shown[pix_idx], model_color[pix_idx]));
        end
        // age the pixel the way the display does when it is shown
        if (model_age[pix_idx] != '0) begin
          model_age[pix_idx] = model_age[pix_idx] - 1'b1;
          if (model_age[pix_idx] == age_t'(`FADE_DIM_AGE)) begin
            model_color[pix_idx] = halve_color(model_color[pix_idx]);
          end else if (model_age[pix_idx] == '0) begin
            model_color[pix_idx] = '0;
          end
        end
        pix_idx = (pix_idx == NPIX - 1) ? 0 : pix_idx + 1;
        if (pix_idx == 0) begin
          frames_shown++;
        end
      end
      if (gfx_credit) begin
        if (outstanding == 0) begin
          report_error("credit returned with no draw outstanding");
        end else begin
          outstanding--;
        end
        credits_seen++;
        if (credit_armed) begin
          first_credit_t = $time;
          credit_armed   = 1'b0;
        end
      end
      if (gfx_push) begin
        outstanding++;
      end
      if (vga_out.visible) begin
        vis_run++;
      end else if (vis_run != 0) begin
        if (timing_on && vis_run != `FB_H_VISIBLE) begin
          report_error($sformatf("visible run of %0d pixels", vis_run));
        end
        timing_checks += timing_on;
        vis_lines++;
        vis_run = 0;
      end
      if (vga_out.hsync) begin
        hs_run++;
      end else if (hs_run != 0) begin
        if (timing_on && hs_run != `FB_H_SYNC) begin
          report_error($sformatf("hsync lasted %0d cycles", hs_run));
        end
        hs_run = 0;
      end
      if (vga_out.vsync) begin
        if (vs_run == 0 && timing_on && vis_lines != `FB_V_VISIBLE) begin
          report_error($sformatf("frame had %0d visible lines", vis_lines));
        end
        vis_lines = vs_run == 0 ? 0 : vis_lines;
        vs_run++;
      end else if (vs_run != 0) begin
        if (timing_on && vs_run != `FB_V_SYNC * `FB_H_WHOLE) begin
          report_error($sformatf("vsync lasted %0d cycles", vs_run));
        end
        vs_run = 0;
      end
    end
  end

  task automatic wait_vsync();
    int n;
    n = 0;
    while (vga_out.vsync && n < 2 * FRAME_CYCLES) begin
      @(negedge clk);
      n++;
    end
    while (!vga_out.vsync && n < 2 * FRAME_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!vga_out.vsync) begin
      errors++;
      $display("vsync did not arrive within two frames");
    end
  endtask

  task automatic wait_frame();
    int start;
    int n;
    start = frames_shown;
    n     = 0;
    while (frames_shown == start && n < 3 * FRAME_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (frames_shown == start) begin
      errors++;
      $display("no complete frame was shown in time");
    end
  endtask

  // starts at a falling edge and returns one falling edge after the push
  task automatic push_cmd(input fb_x_t x, input fb_y_t y, input color_t c);
    int n;
    n = 0;
    while (outstanding >= `GFX_CREDITS && n < 64) begin
      @(negedge clk);
      n++;
    end
    if (outstanding >= `GFX_CREDITS) begin
      errors++;
      $display("no credit came back for a queued draw");
    end
    gfx_cmd.x     = x;
    gfx_cmd.y     = y;
    gfx_cmd.color = c;
    gfx_push      = 1'b1;
    model_age[int'(y) * `FB_H_VISIBLE + int'(x)]   = age_t'(`FADE_START_AGE);
    model_color[int'(y) * `FB_H_VISIBLE + int'(x)] = c;
    @(negedge clk);
    gfx_push = 1'b0;
  endtask

  task automatic push_random();
    push_cmd(fb_x_t'($urandom_range(`FB_H_VISIBLE - 1, 0)),
             fb_y_t'($urandom_range(`FB_V_VISIBLE - 1, 0)), color_t'($urandom));
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_err0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  initial begin
    int     px;
    int     n;
    int     pause_len;
    int     idx_stop;
    color_t c;
    color_t fade_seq [5];
    time    t_push;
    int     credits0;

    void'($urandom(93));
    arst_n        = 1'b0;
    vga_enable    = 1'b1;
    gfx_push      = 1'b0;
    gfx_cmd       = '0;
    errors        = 0;
    test_err0     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    frames_shown  = 0;
    credits_seen  = 0;
    credit_armed  = 1'b0;
    timing_on     = 1'b0;
    timing_checks = 0;
    for (n = 0; n < NPIX; n++) begin
      model_age[n]   = '0;
      model_color[n] = '0;
    end

    // test 1 checks idle outputs around reset and then a black frame
    for (n = 0; n <= 10; n++) begin
      @(negedge clk);
      if (gfx_credit !== 1'b0 || vga_out !== '0) begin
        report_error("outputs not idle around reset");
      end
      arst_n = (n >= 9);
    end
    wait_frame();
    finish_test("reset state");

    // test 2 follows one pixel over five frames
    wait_vsync();
    px = $urandom_range(NPIX - 1, 0);
    c  = color_t'($urandom_range(12'hfff, 1));
    push_cmd(fb_x_t'(px % `FB_H_VISIBLE), fb_y_t'(px / `FB_H_VISIBLE), c);
    fade_seq = '{c, c, halve_color(c), halve_color(c), '0};
    for (n = 0; n < 5; n++) begin
      wait_frame();
      if (shown[px] !== fade_seq[n]) begin
        report_error($sformatf("frame %0d pixel %0d shows %h, expected %h",
                               n, px, shown[px], fade_seq[n]));
      end
    end
    finish_test("single pixel fade");

    // test 3 draws at random with random gaps in each blanking
    for (n = 0; n < 20; n++) begin
      wait_vsync();
      repeat ($urandom_range(6, 0)) begin
        repeat ($urandom_range(3, 0)) @(negedge clk);
        push_random();
      end
    end
    wait_frame();
    finish_test("random drawing");

    // test 4 bursts four draws into an empty queue
    wait_vsync();
    credits0     = credits_seen;
    credit_armed = 1'b1;
    t_push       = $time;
    repeat (4) push_random();
    repeat (8) @(negedge clk);
    if (credits_seen - credits0 != 4) begin
      report_error($sformatf("%0d credits for 4 pushes", credits_seen - credits0));
    end
    if (first_credit_t != t_push + CLK_PERIOD / 2 + CLK_PERIOD) begin
      report_error($sformatf("first credit at %0t, push driven at %0t", first_credit_t, t_push));
    end
    finish_test("credits");

    // test 5 measures line and frame timing over two full frames
    wait_frame();
    timing_on = 1'b1;
    wait_frame();
    wait_frame();
    timing_on = 1'b0;
    if (timing_checks < 2 * `FB_V_VISIBLE) begin
      errors++;
      $display("raster timing was measured on too few lines");
    end
    finish_test("raster timing");

    // test 6 stops the raster mid-frame so outputs go dark and nothing ages
    wait_vsync();
    idx_stop = $urandom_range(100, 20);
    // lit pixels where the raster stands still
    for (n = 0; n < 4; n++) begin
      px = idx_stop + n;
      push_cmd(fb_x_t'(px % `FB_H_VISIBLE), fb_y_t'(px / `FB_H_VISIBLE),
               color_t'($urandom_range(12'hfff, 1)));
    end
    repeat (4) push_random();
    n = 0;
    while (pix_idx < idx_stop && n < 2 * FRAME_CYCLES) begin
      @(negedge clk);
      n++;
    end
    vga_enable = 1'b0;
    pause_len  = $urandom_range(60, 4);
    for (n = 0; n < pause_len; n++) begin
      @(negedge clk);
      if (n >= 1 && vga_out.visible !== 1'b0) begin
        report_error("visible high while the raster is paused");
      end
    end
    vga_enable = 1'b1;
    wait_frame();
    wait_frame();
    finish_test("pause");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog covers the frames the tests need plus a few spare
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d frames, the tests did not finish", RUN_FRAMES + 4);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // first rising edge half a period after time zero
  always begin
    #(PERIOD_NS / 2.0);
    clk = ~clk;
  end

endmodule
